// File: dv/valu_tb.sv
/*
 * Testbench of the vector integer ALU lane
 * Clock, reset, DUT instance, LFSR stimulus, per-element reference model,
 * compare tasks and directed tests
 */

`timescale 1ns/1ps

module valu_tb import valu_pkg::*; ();

  localparam int unsigned InsnQueueDepth = 4;
  localparam time         ClkPeriod      = 40ns;
  localparam logic [15:0] LfsrSeed       = 16'd13162;
  localparam int          TimeoutCycles  = 2000;

  // Operand pair and mask for one word
  typedef struct packed {
    elen_u vs1;
    elen_u vs2;
    strb_t mask;
  } opnd_t;

  logic               clk_i;
  logic               rst_ni;
  vfu_op_t            op_i;
  logic               op_valid_i;
  logic               op_ready_o;
  elen_u [1:0]        operand_i;
  logic               operand_valid_i;
  logic               operand_ready_o;
  strb_t              mask_i;
  logic               result_req_o;
  result_t            result_o;
  logic               result_gnt_i;
  logic [NrVInsn-1:0] done_o;

  // Pending stimulus and expected responses, all in order
  vfu_op_t op_q[$];
  opnd_t   opnd_q[$];
  result_t exp_q[$];
  vid_t    done_q[$];

  logic [15:0] lfsr_q;
  vid_t        next_id;
  int          accepted;
  int          value_errs;
  int          other_errs;

  valu_top #(
    .InsnQueueDepth   (InsnQueueDepth),
    .ResultQueueDepth (2)
  ) dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .op_i            (op_i),
    .op_valid_i      (op_valid_i),
    .op_ready_o      (op_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .result_req_o    (result_req_o),
    .result_o        (result_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_step()};
    end
    return r;
  endfunction

  // Expected write of word w, element by element
  function automatic result_t model_word(vfu_op_t op, opnd_t opnd, int w);
    result_t     r;
    int          ew, epw, left, cnt;
    logic [63:0] a, b, y, m, res;
    ew   = 8 << op.vew;
    epw  = 8 >> op.vew;
    left = int'(op.vl) - w * epw;
    cnt  = (left < epw) ? left : epw;
    m    = (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
    res  = '0;
    for (int e = 0; e < epw; e++) begin
      b = (opnd.vs2.d >> (e * ew)) & m;
      // Scalar low bits stand in for every vs1 element
      a = op.use_scalar ? (op.scalar & m) : ((opnd.vs1.d >> (e * ew)) & m);
      case (op.op)
        OP_ADD:  y = b + a;
        OP_SUB:  y = b - a;
        OP_AND:  y = b & a;
        OP_OR:   y = b | a;
        OP_XOR:  y = b ^ a;
        default: y = '0;
      endcase
      // Masking drops the carry out of the element
      res = res | ((y & m) << (e * ew));
    end
    r.id      = op.id;
    r.addr    = vaddr_t'(int'(op.vd) * 8 + w);
    r.wdata.d = res;
    for (int i = 0; i < 8; i++) begin
      r.be[i] = ((i / (ew / 8)) < cnt);
    end
    if (!op.vm) begin
      r.be = r.be & opnd.mask;
    end
    r.last = (left <= epw);
    return r;
  endfunction

  function automatic vfu_op_t make_op(alu_op_e op, vew_e vew, int vl, logic use_scalar,
                                      logic vm);
    vfu_op_t o;
    o.op         = op;
    o.vew        = vew;
    o.vl         = vl_t'(vl);
    o.vd         = vreg_t'(rand_bits(3));
    o.id         = next_id;
    o.use_scalar = use_scalar;
    o.vm         = vm;
    o.scalar     = rand_bits(64);
    next_id      = next_id + vid_t'(1);
    return o;
  endfunction

  // Queue an instruction with random operands and its expected words
  task automatic queue_insn(input vfu_op_t op);
    opnd_t opnd;
    int    epw, nw;
    epw = 8 >> op.vew;
    nw  = (int'(op.vl) + epw - 1) / epw;
    for (int w = 0; w < nw; w++) begin
      opnd.vs1.d = rand_bits(64);
      opnd.vs2.d = rand_bits(64);
      opnd.mask  = strb_t'(rand_bits(8));
      opnd_q.push_back(opnd);
      exp_q.push_back(model_word(op, opnd, w));
    end
    op_q.push_back(op);
    done_q.push_back(op.id);
  endtask

  task automatic check_result(input result_t got, input result_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %0t: result id %0d addr %0d data %h be %b last %b", $time,
               got.id, got.addr, got.wdata.d, got.be, got.last,
               ", expected id %0d addr %0d data %h be %b last %b",
               exp.id, exp.addr, exp.wdata.d, exp.be, exp.last);
    end
  endtask

  task automatic check_done(input logic [NrVInsn-1:0] got, input logic [NrVInsn-1:0] exp);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %0t: done_o %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errs++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Drive one cycle at the falling edge, check what the next rising edge takes
  task automatic drive_cycle(input logic gnt);
    result_t            exp;
    logic [NrVInsn-1:0] exp_done;
    @(negedge clk_i);
    op_valid_i = (op_q.size() != 0);
    if (op_valid_i) begin
      op_i = op_q[0];
    end
    operand_valid_i = (opnd_q.size() != 0);
    if (operand_valid_i) begin
      operand_i[0] = opnd_q[0].vs1;
      operand_i[1] = opnd_q[0].vs2;
      mask_i       = opnd_q[0].mask;
    end
    result_gnt_i = gnt;
    #1;
    if (op_valid_i && op_ready_o) begin
      void'(op_q.pop_front());
      accepted++;
    end
    if (operand_ready_o) begin
      void'(opnd_q.pop_front());
    end
    exp_done = '0;
    if (result_req_o && result_gnt_i) begin
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("Result word granted at %0t while none was expected", $time);
      end else begin
        exp = exp_q.pop_front();
        check_result(result_o, exp);
        if (exp.last) begin
          exp_done[done_q.pop_front()] = 1'b1;
        end
      end
    end
    check_done(done_o, exp_done);
  endtask

  // Grant freely until every queued word is written back
  task automatic drain_traffic();
    int cycles;
    cycles = 0;
    while ((op_q.size() + opnd_q.size() + exp_q.size()) != 0 && cycles < TimeoutCycles) begin
      drive_cycle(1'b1);
      cycles++;
    end
    if ((op_q.size() + opnd_q.size() + exp_q.size()) != 0) begin
      other_errs++;
      $display("Timeout at %0t: %0d result words never arrived", $time, exp_q.size());
      op_q.delete();
      opnd_q.delete();
      exp_q.delete();
      done_q.delete();
    end
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    #1;
    check_bit(result_req_o, 1'b0, "result_req_o after reset");
    check_bit(operand_ready_o, 1'b0, "operand_ready_o after reset");
    check_bit(op_ready_o, 1'b1, "op_ready_o after reset");
    check_done(done_o, '0);
  endtask

  task automatic test_vv_widths();
    alu_op_e ops [5];
    ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    // Full register at every width, 8 words each
    for (int k = 0; k < 5; k++) begin
      for (int v = 0; v < 4; v++) begin
        queue_insn(make_op(ops[k], vew_e'(v), 64 >> v, 1'b0, 1'b1));
      end
    end
    drain_traffic();
  endtask

  task automatic test_scalar();
    for (int v = 0; v < 4; v++) begin
      queue_insn(make_op(OP_ADD, vew_e'(v), 64 >> v, 1'b1, 1'b1));
      queue_insn(make_op(OP_SUB, vew_e'(v), 64 >> v, 1'b1, 1'b1));
      queue_insn(make_op(OP_XOR, vew_e'(v), 32 >> v, 1'b1, 1'b1));
    end
    drain_traffic();
  endtask

  task automatic test_tail();
    // Lengths that leave a partial last word
    queue_insn(make_op(OP_ADD, EW8, 13, 1'b0, 1'b1));
    queue_insn(make_op(OP_SUB, EW8, 1, 1'b0, 1'b1));
    queue_insn(make_op(OP_OR, EW16, 5, 1'b0, 1'b1));
    queue_insn(make_op(OP_ADD, EW16, 31, 1'b1, 1'b1));
    queue_insn(make_op(OP_XOR, EW32, 3, 1'b0, 1'b1));
    queue_insn(make_op(OP_AND, EW32, 15, 1'b0, 1'b1));
    queue_insn(make_op(OP_SUB, EW64, 5, 1'b0, 1'b1));
    drain_traffic();
  endtask

  task automatic test_mask();
    for (int v = 0; v < 4; v++) begin
      queue_insn(make_op(OP_ADD, vew_e'(v), 64 >> v, 1'b0, 1'b0));
      queue_insn(make_op(OP_XOR, vew_e'(v), (64 >> v) - 1, 1'b1, 1'b0));
      queue_insn(make_op(OP_SUB, vew_e'(v), 16 >> v, 1'b0, 1'b1));
    end
    drain_traffic();
  endtask

  task automatic test_backpressure();
    int   cycles;
    logic stalled;
    for (int i = 0; i < 6; i++) begin
      queue_insn(make_op(OP_ADD, EW32, 16, 1'b0, 1'b1));
    end
    accepted = 0;
    cycles   = 0;
    stalled  = 1'b0;
    // Grant held low, accept until the store is full
    while (!stalled && cycles < TimeoutCycles) begin
      drive_cycle(1'b0);
      cycles++;
      stalled = !op_ready_o;
    end
    if (!stalled) begin
      other_errs++;
      $display("Timeout at %0t: op_ready_o never fell with the grant held low", $time);
    end
    check_bit(accepted == InsnQueueDepth, 1'b1, "accept count at op_ready_o fall");
    repeat (4) begin
      drive_cycle(1'b0);
      check_bit(op_ready_o, 1'b0, "op_ready_o while stalled");
      check_bit(result_req_o, 1'b1, "result_req_o while stalled");
      check_bit(operand_ready_o, 1'b0, "operand_ready_o while stalled");
    end
    drain_traffic();
  endtask

  initial begin
    rst_ni          = 1'b0;
    op_i            = '0;
    op_valid_i      = 1'b0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    mask_i          = '0;
    result_gnt_i    = 1'b0;
    lfsr_q          = LfsrSeed;
    next_id         = '0;
    accepted        = 0;
    value_errs      = 0;
    other_errs      = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset();
    test_vv_widths();
    test_scalar();
    test_tail();
    test_mask();
    test_backpressure();
    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the vector ALU testbench with Verilator and run it
# The run counts as passed only when the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f sim.f --top-module valu_tb &&
out="$(./obj_dir/Vvalu_tb)" &&
echo "$out" &&
echo "$out" | grep -qx "=== PASS ===" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: sim.f
source/valu_pkg.sv
source/valu_insn_queue.sv
source/valu_issue_ctrl.sv
source/simd_alu.sv
source/valu_result_queue.sv
source/valu_top.sv
dv/valu_tb.sv

// File: source/simd_alu.sv
/*
 * Combinational SIMD integer unit
 * ADD, SUB, AND, OR, XOR on 8, 16, 32 or 64-bit elements of one word
 */

`timescale 1ns/1ps

module simd_alu import valu_pkg::*; (
  input  elen_u   a_i,
  input  elen_u   b_i,
  input  alu_op_e op_i,
  input  vew_e    vew_i,
  output elen_u   result_o
);

  logic sub;

  // Result is vs2 minus vs1
  assign sub = (op_i == OP_SUB);

  always_comb begin
    result_o = '0;
    case (op_i)
      // Bitwise ops have no element boundaries
      OP_AND: result_o.d = b_i.d & a_i.d;
      OP_OR:  result_o.d = b_i.d | a_i.d;
      OP_XOR: result_o.d = b_i.d ^ a_i.d;
      OP_ADD, OP_SUB: begin
        // One adder per element, carries stop at the element edge
        case (vew_i)
          EW8: begin
            for (int i = 0; i < ElenBits / 8; i++) begin
              result_o.b[i] = sub ? b_i.b[i] - a_i.b[i] : b_i.b[i] + a_i.b[i];
            end
          end
          EW16: begin
            for (int i = 0; i < ElenBits / 16; i++) begin
              result_o.h[i] = sub ? b_i.h[i] - a_i.h[i] : b_i.h[i] + a_i.h[i];
            end
          end
          EW32: begin
            for (int i = 0; i < ElenBits / 32; i++) begin
              result_o.w[i] = sub ? b_i.w[i] - a_i.w[i] : b_i.w[i] + a_i.w[i];
            end
          end
          default: begin
            result_o.d = sub ? b_i.d - a_i.d : b_i.d + a_i.d;
          end
        endcase
      end
      default: result_o = '0;
    endcase
  end

endmodule

// File: source/valu_insn_queue.sv
/*
 * Instruction store of the vector ALU
 * Ring of pending operations with accept and issue pointers,
 * issue and commit occupancy counts, one-hot done generation
 */

`timescale 1ns/1ps

module valu_insn_queue import valu_pkg::*; #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  vfu_op_t            op_i,
  input  logic               op_valid_i,
  output logic               op_ready_o,
  output vfu_op_t            issue_op_o,
  output logic               issue_valid_o,
  input  logic               issue_done_i,
  input  logic               commit_i,
  input  vid_t               commit_id_i,
  output logic [NrVInsn-1:0] done_o
);

  localparam int unsigned PtrBits = $clog2(InsnQueueDepth);

  typedef logic [PtrBits-1:0] ptr_t;
  typedef logic [PtrBits:0]   cnt_t;

  // Operation storage, payload only
  vfu_op_t insn_q [InsnQueueDepth];

  ptr_t accept_pnt_q, issue_pnt_q;
  // Instructions waiting to be issued, and waiting to be fully written back
  cnt_t issue_cnt_q, commit_cnt_q;

  logic accept;

  // Ring pointer increment with wrap at the queue depth
  function automatic ptr_t next_ptr(ptr_t p);
    if (p == ptr_t'(InsnQueueDepth - 1)) begin
      return '0;
    end
    return p + ptr_t'(1);
  endfunction

  // An entry stays occupied until its last word is written back
  assign op_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign accept     = op_valid_i && op_ready_o;

  // Head of the issue phase
  assign issue_op_o    = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  // Done pulse follows the write-back of the last word
  always_comb begin
    done_o = '0;
    if (commit_i) begin
      done_o[commit_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= op_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_ptr(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= next_ptr(issue_pnt_q);
      end
      // Accept and retire may coincide in one cycle
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_i);
    end
  end

endmodule

// File: source/valu_issue_ctrl.sv
/*
 * Issue controller of the vector ALU
 * Walks the head instruction one word per cycle, replicates the scalar,
 * builds address, byte enables and last flag, pushes into the result queue
 */

`timescale 1ns/1ps

module valu_issue_ctrl import valu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  vfu_op_t     issue_op_i,
  input  logic        issue_valid_i,
  input  elen_u [1:0] operand_i,
  input  logic        operand_valid_i,
  output logic        operand_ready_o,
  input  strb_t       mask_i,
  output elen_u       alu_a_o,
  output elen_u       alu_b_o,
  input  elen_u       alu_result_i,
  output logic        push_o,
  output result_t     push_data_o,
  input  logic        full_i,
  output logic        issue_done_o
);

  // Elements of the current instruction already issued
  vl_t elem_q;

  vl_t   remaining;
  vl_t   epw;
  vl_t   elem_cnt;
  logic  last;
  strb_t be_elem;
  elen_u scalar_rep;

  assign remaining = issue_op_i.vl - elem_q;
  // Elements per word, 8 bytes divided by the element size
  assign epw       = vl_t'(StrbBits) >> issue_op_i.vew;
  assign elem_cnt  = (remaining < epw) ? remaining : epw;
  // Remaining count reaches zero with this word
  assign last      = (remaining <= epw);

  // Bytes of the elements still inside the vector length
  always_comb begin
    for (int i = 0; i < StrbBits; i++) begin
      be_elem[i] = ((vl_t'(i) >> issue_op_i.vew) < elem_cnt);
    end
  end

  // Scalar copied into every element slot
  always_comb begin
    case (issue_op_i.vew)
      EW8:     scalar_rep.d = {8{issue_op_i.scalar[7:0]}};
      EW16:    scalar_rep.d = {4{issue_op_i.scalar[15:0]}};
      EW32:    scalar_rep.d = {2{issue_op_i.scalar[31:0]}};
      default: scalar_rep.d = issue_op_i.scalar;
    endcase
  end

  // vs1 in slot 0, vs2 in slot 1
  assign alu_a_o = issue_op_i.use_scalar ? scalar_rep : operand_i[0];
  assign alu_b_o = operand_i[1];

  // Operands and mask are consumed with the push
  assign push_o          = issue_valid_i && operand_valid_i && !full_i;
  assign operand_ready_o = push_o;
  assign issue_done_o    = push_o && last;

  always_comb begin
    push_data_o.id    = issue_op_i.id;
    // Base of vd plus the word index inside the instruction
    push_data_o.addr  = {issue_op_i.vd, 3'b000} +
                        vaddr_t'(elem_q >> (2'd3 - 2'(issue_op_i.vew)));
    push_data_o.wdata = alu_result_i;
    push_data_o.be    = be_elem & (issue_op_i.vm ? '1 : mask_i);
    push_data_o.last  = last;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      elem_q <= '0;
    end else if (push_o) begin
      // Next instruction starts from its first element
      elem_q <= last ? '0 : elem_q + elem_cnt;
    end
  end

endmodule

// File: source/valu_pkg.sv
/*
 * Shared definitions of the vector integer ALU lane
 * Datapath widths, id and address types, element width and opcode enums,
 * the SIMD data-word union, the operation and result structs
 */

package valu_pkg;

  // Datapath geometry
  localparam int unsigned ElenBits = 64;
  localparam int unsigned StrbBits = ElenBits / 8;
  // Number of instruction ids in the machine
  localparam int unsigned NrVInsn  = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  // Register-file word address, eight words per vector register
  typedef logic [5:0]                 vaddr_t;
  // Vector length in elements, up to 64
  typedef logic [6:0]                 vl_t;
  typedef logic [2:0]                 vreg_t;
  typedef logic [StrbBits-1:0]        strb_t;

  // Element width, encoded as log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4
  } alu_op_e;

  // One 64-bit word seen as packed SIMD elements
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    logic [63:0]      d;
  } elen_u;

  // Operation handed over by the lane sequencer
  typedef struct packed {
    alu_op_e               op;
    vew_e                  vew;
    vl_t                   vl;
    vreg_t                 vd;
    vid_t                  id;
    logic                  use_scalar;
    // Set when the instruction is unmasked
    logic                  vm;
    logic [ElenBits-1:0]   scalar;
  } vfu_op_t;

  // One register-file write, last marks the final word of an instruction
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_u  wdata;
    strb_t  be;
    logic   last;
  } result_t;

endpackage

// File: source/valu_result_queue.sv
/*
 * Result FIFO in front of the register-file write port
 * Request while the head is valid, pop on grant, flag commit of last words
 */

`timescale 1ns/1ps

module valu_result_queue import valu_pkg::*; #(
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    push_i,
  input  result_t push_data_i,
  output logic    full_o,
  output logic    result_req_o,
  output result_t result_o,
  input  logic    result_gnt_i,
  output logic    commit_o,
  output vid_t    commit_id_o
);

  localparam int unsigned PtrBits = $clog2(ResultQueueDepth);

  typedef logic [PtrBits-1:0] ptr_t;
  typedef logic [PtrBits:0]   cnt_t;

  result_t fifo_q [ResultQueueDepth];

  ptr_t wr_pnt_q, rd_pnt_q;
  cnt_t cnt_q;
  logic pop;

  function automatic ptr_t next_ptr(ptr_t p);
    if (p == ptr_t'(ResultQueueDepth - 1)) begin
      return '0;
    end
    return p + ptr_t'(1);
  endfunction

  assign full_o       = (cnt_q == cnt_t'(ResultQueueDepth));
  // Head entry is on the write port while the queue holds anything
  assign result_req_o = (cnt_q != '0);
  assign result_o     = fifo_q[rd_pnt_q];
  assign pop          = result_req_o && result_gnt_i;

  // Last word of an instruction written back
  assign commit_o    = pop && result_o.last;
  assign commit_id_o = result_o.id;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      fifo_q[wr_pnt_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= next_ptr(wr_pnt_q);
      end
      if (pop) begin
        rd_pnt_q <= next_ptr(rd_pnt_q);
      end
      cnt_q <= cnt_q + cnt_t'(push_i) - cnt_t'(pop);
    end
  end

endmodule

// File: source/valu_top.sv
/*
 * Vector integer ALU lane top level
 * Instruction store, issue controller, SIMD unit and result queue
 */

`timescale 1ns/1ps

module valu_top import valu_pkg::*; #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Operation from the sequencer
  input  vfu_op_t            op_i,
  input  logic               op_valid_i,
  output logic               op_ready_o,
  // Operand words, vs1 in slot 0, vs2 in slot 1
  input  elen_u [1:0]        operand_i,
  input  logic               operand_valid_i,
  output logic               operand_ready_o,
  input  strb_t              mask_i,
  // Register-file write port
  output logic               result_req_o,
  output result_t            result_o,
  input  logic               result_gnt_i,
  output logic [NrVInsn-1:0] done_o
);

  vfu_op_t issue_op;
  logic    issue_valid;
  logic    issue_done;
  elen_u   alu_a, alu_b, alu_result;
  logic    push, full;
  result_t push_data;
  logic    commit_pulse;
  vid_t    commit_id;

  valu_insn_queue #(
    .InsnQueueDepth(InsnQueueDepth)
  ) i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .op_i          (op_i),
    .op_valid_i    (op_valid_i),
    .op_ready_o    (op_ready_o),
    .issue_op_o    (issue_op),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .commit_i      (commit_pulse),
    .commit_id_i   (commit_id),
    .done_o        (done_o)
  );

  valu_issue_ctrl i_issue_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_op_i      (issue_op),
    .issue_valid_i   (issue_valid),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mask_i          (mask_i),
    .alu_a_o         (alu_a),
    .alu_b_o         (alu_b),
    .alu_result_i    (alu_result),
    .push_o          (push),
    .push_data_o     (push_data),
    .full_i          (full),
    .issue_done_o    (issue_done)
  );

  // Op and element width come straight from the issuing instruction
  simd_alu i_simd_alu (
    .a_i      (alu_a),
    .b_i      (alu_b),
    .op_i     (issue_op.op),
    .vew_i    (issue_op.vew),
    .result_o (alu_result)
  );

  valu_result_queue #(
    .ResultQueueDepth(ResultQueueDepth)
  ) i_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_data_i  (push_data),
    .full_o       (full),
    .result_req_o (result_req_o),
    .result_o     (result_o),
    .result_gnt_i (result_gnt_i),
    .commit_o     (commit_pulse),
    .commit_id_o  (commit_id)
  );

endmodule
